/* hdl/out_layer_pkg.sv */
// Format is signed s5.10 in 16 bits and frames hold FRAME_LEN neurons, so stimulus must follow both
`default_nettype none

package out_layer_pkg;

	// Fixed-point format
	localparam int DATA_W = 16;    // Width of every fixed-point word
	localparam int INT_BITS = 5;   // Integer bits, sign bit not counted
	localparam int FRAC_BITS = 10; // Fraction bits

	// Frame geometry, one word per output neuron
	localparam int FRAME_LEN = 4;                      // Neurons per frame and depth of each bank
	localparam int ADDR_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1; // Bank address width

	typedef logic signed [DATA_W-1:0] fix_t; // One fixed-point word

	// Saturation bounds and the value 1.0
	localparam fix_t FIX_MAX = {1'b0, {(DATA_W-1){1'b1}}}; // Most positive word
	localparam fix_t FIX_MIN = {1'b1, {(DATA_W-1){1'b0}}}; // Most negative word
	localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);     // Label 1 in fixed point

	// Cost function picked per sample
	typedef enum logic {
		COST_XENT = 1'b0, // Cross-entropy, delta is a minus y
		COST_QUAD = 1'b1  // Quadratic, (a minus y) times sigmoid prime
	} cost_e;

	// One input beat for a single output neuron
	typedef struct packed {
		fix_t  act;  // Activation from the previous layer
		fix_t  sp;   // Sigmoid prime of the same neuron
		logic  y;    // Ideal output bit
		cost_e cost; // Cost opcode
	} sample_t;

	// One output beat toward the previous layer
	typedef struct packed {
		fix_t delta; // Backpropagated delta
		logic last;  // High on the final neuron of a frame
	} delta_t;

	// Read port request into the delta banks
	typedef struct packed {
		logic              en;   // Read strobe
		logic [ADDR_W-1:0] addr; // Word address inside the read bank
	} mem_rd_req_t;

endpackage

`default_nettype wire

/* hdl/delta_calc.sv */
// One delta per accepted sample with one output register, so a stalled consumer holds one item only
`timescale 1ns/1ps
`default_nettype none

module delta_calc (
	input  wire                     clk,
	input  wire                     arst_n_i,
	input  wire out_layer_pkg::sample_t sample_i,
	input  wire                     sample_valid_i,
	output logic                    sample_ready_o,
	output out_layer_pkg::fix_t     wr_data_o,
	output logic                    wr_valid_o,
	input  wire                     wr_ready_i
);

	// Clamp a wide signed value to the fix_t range
	function automatic out_layer_pkg::fix_t sat_fix(
		input logic signed [2*out_layer_pkg::DATA_W-1:0] v
	);
		if (v > out_layer_pkg::FIX_MAX)
			return out_layer_pkg::FIX_MAX;
		else if (v < out_layer_pkg::FIX_MIN)
			return out_layer_pkg::FIX_MIN;
		else
			return v[out_layer_pkg::DATA_W-1:0]; // In range, low word keeps the value
	endfunction

	out_layer_pkg::fix_t label_fix; // y as 1.0 or 0
	out_layer_pkg::fix_t diff_sat;  // a minus y after clamping
	out_layer_pkg::fix_t quad_sat;  // Quadratic delta after clamping
	out_layer_pkg::fix_t delta_nxt; // Delta picked by the opcode
	logic signed [2*out_layer_pkg::DATA_W-1:0] diff_wide; // Unclamped difference
	logic signed [2*out_layer_pkg::DATA_W-1:0] prod;      // Full s11.20 product
	logic signed [2*out_layer_pkg::DATA_W-1:0] prod_shr;  // Product back at 10 fraction bits
	logic accept; // Sample handshake fires

	always_comb begin
		label_fix = sample_i.y ? out_layer_pkg::FIX_ONE : '0;
		diff_wide = sample_i.act - label_fix; // Signed, widened before the subtract
		diff_sat = sat_fix(diff_wide);
		prod = diff_sat * sample_i.sp;        // 16x16 fits in 32 bits
		prod_shr = prod >>> out_layer_pkg::FRAC_BITS; // Floor, rounds toward minus infinity
		quad_sat = sat_fix(prod_shr);
		if (sample_i.cost == out_layer_pkg::COST_QUAD)
			delta_nxt = quad_sat;
		else
			delta_nxt = diff_sat; // Cross-entropy skips the multiply
	end

	// Take a new sample when the register is empty or drains this cycle
	assign sample_ready_o = !wr_valid_o || wr_ready_i;
	assign accept = sample_valid_i && sample_ready_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_valid_o <= 1'b0;
		end else begin
			if (accept)
				wr_valid_o <= 1'b1;
			else if (wr_ready_i)
				wr_valid_o <= 1'b0; // Taken by the buffer, nothing new behind it
		end
	end

	// Payload register only loads on accept
	always_ff @(posedge clk) begin
		if (accept)
			wr_data_o <= delta_nxt;
	end

	// A stalled delta stays put until the buffer takes it
	a_wr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_data_o))
		else $error("delta_calc: output changed while stalled");

endmodule

`default_nettype wire

/* hdl/delta_pingpong_mem.sv */
// Two banks of FRAME_LEN words, filled and released strictly in turn, read data one cycle after request
`timescale 1ns/1ps
`default_nettype none

module delta_pingpong_mem (
	input  wire                          clk,
	input  wire                          arst_n_i,
	input  wire out_layer_pkg::fix_t     wr_data_i,
	input  wire                          wr_valid_i,
	output logic                         wr_ready_o,
	input  wire out_layer_pkg::mem_rd_req_t rd_req_i,
	output out_layer_pkg::fix_t          rd_data_o,
	output logic                         rd_bank_valid_o,
	input  wire                          rd_release_i
);

	// Bank storage, index 0 or 1 picks the bank
	out_layer_pkg::fix_t mem [2][out_layer_pkg::FRAME_LEN];

	logic                            wr_ptr;  // Bank being filled
	logic [out_layer_pkg::ADDR_W-1:0] wr_addr; // Next word in the write bank
	logic                            rd_ptr;  // Bank being drained
	logic [1:0]                      full;    // One flag per bank
	logic                            wr_fire; // Write handshake
	logic                            wr_last; // Write lands on the final word

	// Writer stalls only when its bank still holds an unreleased frame
	assign wr_ready_o = !full[wr_ptr];
	assign wr_fire = wr_valid_i && wr_ready_o;
	assign wr_last = int'(wr_addr) == out_layer_pkg::FRAME_LEN - 1;
	assign rd_bank_valid_o = full[rd_ptr];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= 1'b0;
			wr_addr <= '0;
			rd_ptr <= 1'b0;
			full <= '0; // Both banks empty
		end else begin
			if (wr_fire) begin
				if (wr_last) begin
					wr_addr <= '0;
					wr_ptr <= !wr_ptr; // Swap on the filling edge
				end else begin
					wr_addr <= wr_addr + 1'b1;
				end
			end
			for (int b = 0; b < 2; b++) begin
				if (wr_fire && wr_last && (wr_ptr == b[0]))
					full[b] <= 1'b1; // Frame complete
				else if (rd_release_i && (rd_ptr == b[0]))
					full[b] <= 1'b0; // Consumer done with it
			end
			if (rd_release_i)
				rd_ptr <= !rd_ptr; // Next frame comes from the other bank
		end
	end

	// Write port
	always_ff @(posedge clk) begin
		if (wr_fire)
			mem[wr_ptr][wr_addr] <= wr_data_i;
	end

	// Read port, registered output
	always_ff @(posedge clk) begin
		if (rd_req_i.en)
			rd_data_o <= mem[rd_ptr][rd_req_i.addr];
	end

	// Stalled writer resumes only after a release, so a full bank is never overwritten
	a_refill_after_release: assert property (@(posedge clk) disable iff (!arst_n_i)
		!wr_ready_o ##1 wr_ready_o |-> $past(rd_release_i))
		else $error("delta_pingpong_mem: write bank freed without release");

	// Consumer reads only a bank that holds a complete frame
	a_rd_needs_bank: assert property (@(posedge clk) disable iff (!arst_n_i)
		rd_req_i.en |-> rd_bank_valid_o)
		else $error("delta_pingpong_mem: read with no valid bank");

endmodule

`default_nettype wire

/* hdl/delta_stream_out.sv */
// Drains one full bank at a time through a two-entry queue, reads throttled so nothing is dropped
`timescale 1ns/1ps
`default_nettype none

module delta_stream_out (
	input  wire                          clk,
	input  wire                          arst_n_i,
	input  wire                          rd_bank_valid_i,
	output out_layer_pkg::mem_rd_req_t   rd_req_o,
	output logic                         rd_release_o,
	input  wire out_layer_pkg::fix_t     rd_data_i,
	output out_layer_pkg::delta_t        delta_o,
	output logic                         delta_valid_o,
	input  wire                          delta_ready_i
);

	typedef enum logic {
		ST_FETCH,  // Issue reads from the valid bank
		ST_RELEASE // One cycle release pulse
	} state_e;

	state_e                           state;
	logic [out_layer_pkg::ADDR_W-1:0] rd_addr;       // Next word to read
	logic                             rd_fire;       // Read issued this cycle
	logic                             rd_last;       // Current address is the final word
	logic                             inflight;      // Read data arrives this cycle
	logic                             inflight_last; // Arriving word ends the frame
	out_layer_pkg::delta_t            q [2];         // Holding queue
	logic                             q_wr;          // Queue write slot
	logic                             q_rd;          // Queue head slot
	logic [1:0]                       q_cnt;         // Words held, 0 to 2
	logic                             pop;           // Output handshake
	logic [1:0]                       credit_used;   // Slots claimed after this cycle's pop

	assign pop = delta_valid_o && delta_ready_i;
	assign rd_last = int'(rd_addr) == out_layer_pkg::FRAME_LEN - 1;
	assign credit_used = q_cnt + {1'b0, inflight} - {1'b0, pop};

	// Read only with a free slot for the returning word
	assign rd_fire = (state == ST_FETCH) && rd_bank_valid_i && (credit_used < 2'd2);

	always_comb begin
		rd_req_o.en = rd_fire;
		rd_req_o.addr = rd_addr;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= ST_FETCH;
			rd_addr <= '0;
			inflight <= 1'b0;
			inflight_last <= 1'b0;
			q_wr <= 1'b0;
			q_rd <= 1'b0;
			q_cnt <= '0;
		end else begin
			inflight <= rd_fire; // Memory answers next cycle
			inflight_last <= rd_fire && rd_last;
			case (state)
				ST_FETCH: if (rd_fire && rd_last) state <= ST_RELEASE;
				ST_RELEASE: state <= ST_FETCH; // Bank pointer moves on this edge
				default: state <= ST_FETCH;
			endcase
			if (rd_fire)
				rd_addr <= rd_last ? '0 : rd_addr + 1'b1;
			if (inflight)
				q_wr <= !q_wr;
			if (pop)
				q_rd <= !q_rd;
			q_cnt <= q_cnt + {1'b0, inflight} - {1'b0, pop};
		end
	end

	// Queue storage, data only
	always_ff @(posedge clk) begin
		if (inflight)
			q[q_wr] <= '{delta: rd_data_i, last: inflight_last};
	end

	assign delta_o = q[q_rd];
	assign delta_valid_o = q_cnt != 2'd0;
	assign rd_release_o = state == ST_RELEASE;

	// Release only while the bank is presented, and no second one before a whole new frame
	a_one_release: assert property (@(posedge clk) disable iff (!arst_n_i)
		rd_release_o |-> rd_bank_valid_i ##1 (!rd_release_o [*out_layer_pkg::FRAME_LEN]))
		else $error("delta_stream_out: extra release in one bank period");

endmodule

`default_nettype wire

/* hdl/output_layer_top.sv */
// Output layer delta pipeline, latency depends on back-pressure and up to two frames sit in the banks
`timescale 1ns/1ps
`default_nettype none

module output_layer_top (
	input  wire                         clk,
	input  wire                         arst_n_i,
	input  wire out_layer_pkg::sample_t sample_i,
	input  wire                         sample_valid_i,
	output logic                        sample_ready_o,
	output out_layer_pkg::delta_t       delta_o,
	output logic                        delta_valid_o,
	input  wire                         delta_ready_i
);

	out_layer_pkg::fix_t        wr_data;       // Producer to buffer
	logic                       wr_valid;
	logic                       wr_ready;
	out_layer_pkg::mem_rd_req_t rd_req;        // Consumer read request
	out_layer_pkg::fix_t        rd_data;       // Buffer read data
	logic                       rd_bank_valid; // A full bank waits for draining
	logic                       rd_release;    // Consumer finished the bank

	// Delta computation
	delta_calc u_delta_calc (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.sample_i      (sample_i),
		.sample_valid_i(sample_valid_i),
		.sample_ready_o(sample_ready_o),
		.wr_data_o     (wr_data),
		.wr_valid_o    (wr_valid),
		.wr_ready_i    (wr_ready)
	);

	// Ping-pong delta memory
	delta_pingpong_mem u_delta_mem (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.wr_data_i      (wr_data),
		.wr_valid_i     (wr_valid),
		.wr_ready_o     (wr_ready),
		.rd_req_i       (rd_req),
		.rd_data_o      (rd_data),
		.rd_bank_valid_o(rd_bank_valid),
		.rd_release_i   (rd_release)
	);

	// Stream toward the previous layer
	delta_stream_out u_delta_stream (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.rd_bank_valid_i(rd_bank_valid),
		.rd_req_o       (rd_req),
		.rd_release_o   (rd_release),
		.rd_data_i      (rd_data),
		.delta_o        (delta_o),
		.delta_valid_o  (delta_valid_o),
		.delta_ready_i  (delta_ready_i)
	);

endmodule

`default_nettype wire

/* test/tb_output_layer.sv */
// Samples go in whole frames so every frame drains, and the run stops at the first mismatch or timeout
`timescale 1ns/1ps
`default_nettype none

module tb_output_layer;

	typedef enum {READY_ALWAYS, READY_RANDOM, READY_STALL} ready_mode_e; // Output sink behavior

	logic                          clk;
	logic                          arst_n_i;
	out_layer_pkg::sample_t        sample_i;
	logic                          sample_valid_i;
	logic                          sample_ready_o;
	out_layer_pkg::delta_t         delta_o;
	logic                          delta_valid_o;
	logic                          delta_ready_i;

	out_layer_pkg::delta_t exp_q [$]; // Expected deltas in input order
	out_layer_pkg::delta_t exp_item;  // Head popped by the comparator
	ready_mode_e           ready_mode;
	int                    accepted_cnt; // Samples taken by the DUT
	int                    stall_taken;
	int unsigned           seed_ret;

	output_layer_top dut (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.sample_i      (sample_i),
		.sample_valid_i(sample_valid_i),
		.sample_ready_o(sample_ready_o),
		.delta_o       (delta_o),
		.delta_valid_o (delta_valid_o),
		.delta_ready_i (delta_ready_i)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	task automatic stop_with_failure(input string reason);
		$display("Run aborted: %s at %0t", reason, $time);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input longint got, input longint exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s, got %0d, expected %0d", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// Clamp to the signed 16 bit range
	function automatic longint clamp_fix(input longint v);
		longint hi;
		longint lo;
		hi = (longint'(1) << (out_layer_pkg::DATA_W - 1)) - 1;
		lo = -hi - 1;
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	// Expected delta is a - y and for quadratic cost also times sigmoid prime
	function automatic out_layer_pkg::fix_t expected_delta(input out_layer_pkg::sample_t s);
		longint a;
		longint y;
		longint d;
		a = longint'($signed(s.act));
		y = s.y ? (longint'(1) << out_layer_pkg::FRAC_BITS) : 0; // Label as 1.0 or 0
		d = clamp_fix(a - y);
		if (s.cost == out_layer_pkg::COST_QUAD)
			d = clamp_fix((d * longint'($signed(s.sp))) >>> out_layer_pkg::FRAC_BITS); // Floor
		return out_layer_pkg::fix_t'(d);
	endfunction

	function automatic out_layer_pkg::sample_t random_sample(input out_layer_pkg::cost_e cost);
		out_layer_pkg::sample_t s;
		if ($urandom_range(0, 1) == 0)
			s.act = out_layer_pkg::fix_t'($urandom_range(0, 1024)); // Sigmoid output from 0 to 1.0
		else
			s.act = out_layer_pkg::fix_t'($urandom); // Anywhere in range
		if ($urandom_range(0, 3) == 0)
			s.sp = out_layer_pkg::fix_t'($urandom); // Wide values often saturate
		else
			s.sp = out_layer_pkg::fix_t'($urandom_range(0, 256)); // Up to 0.25
		s.y = 1'($urandom_range(0, 1));
		s.cost = cost;
		return s;
	endfunction

	function automatic out_layer_pkg::sample_t make_sample(input out_layer_pkg::fix_t act,
		input out_layer_pkg::fix_t sp, input logic y, input out_layer_pkg::cost_e cost);
		out_layer_pkg::sample_t s;
		s.act = act;
		s.sp = sp;
		s.y = y;
		s.cost = cost;
		return s;
	endfunction

	// Queue the expected result with last on every fourth
	task automatic record_accepted(input out_layer_pkg::sample_t s);
		out_layer_pkg::delta_t e;
		e.delta = expected_delta(s);
		e.last = (accepted_cnt % out_layer_pkg::FRAME_LEN) == out_layer_pkg::FRAME_LEN - 1;
		exp_q.push_back(e);
		accepted_cnt++;
	endtask

	// Called 2 ns after a rising edge and returns likewise
	task automatic send_sample(input out_layer_pkg::sample_t s);
		int waited;
		waited = 0;
		sample_i = s;
		sample_valid_i = 1'b1;
		@(negedge clk);
		while (!sample_ready_o) begin
			waited++;
			if (waited > 200)
				stop_with_failure("timeout waiting for sample_ready_o");
			@(negedge clk);
		end
		record_accepted(s); // Transfer on the coming edge
		@(posedge clk);
		#2;
		sample_valid_i = 1'b0;
	endtask

	task automatic wait_first_output(input int limit);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!delta_valid_o) begin
			waited++;
			if (waited > limit)
				stop_with_failure("timeout waiting for the first delta");
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	// Pops happen on falling edges, so the size is read on rising ones
	task automatic wait_drained(input int limit);
		int waited;
		waited = 0;
		@(posedge clk);
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > limit)
				stop_with_failure("timeout waiting for all expected deltas");
			@(posedge clk);
		end
		#2;
	endtask

	// Offer samples for a fixed number of cycles with the output stalled
	task automatic fill_under_stall(input int cycles, output int taken);
		out_layer_pkg::sample_t s;
		logic                   took;
		taken = 0;
		s = random_sample(out_layer_pkg::COST_QUAD);
		sample_i = s;
		sample_valid_i = 1'b1;
		repeat (cycles) begin
			@(negedge clk);
			took = sample_ready_o;
			if (took) begin
				record_accepted(s);
				taken++;
			end
			@(posedge clk);
			#2;
			if (took) begin
				s = random_sample(out_layer_pkg::COST_QUAD); // Payload changes only after a transfer
				sample_i = s;
			end
		end
		sample_valid_i = 1'b0;
	endtask

	// Output sink driven 2 ns after the edge
	always @(posedge clk) begin
		#2;
		case (ready_mode)
			READY_ALWAYS: delta_ready_i = 1'b1;
			READY_RANDOM: delta_ready_i = $urandom_range(0, 99) < 60;
			default:      delta_ready_i = 1'b0;
		endcase
	end

	// Comparator samples at the falling edge where outputs are stable
	always @(negedge clk) begin
		if (arst_n_i && delta_valid_o && delta_ready_i) begin
			if (exp_q.size() == 0) begin
				stop_with_failure("DUT produced a delta that was not expected");
			end else begin
				exp_item = exp_q.pop_front();
				check_value("delta value", longint'($signed(delta_o.delta)),
					longint'($signed(exp_item.delta)));
				check_value("last flag", longint'(delta_o.last), longint'(exp_item.last));
			end
		end
	end

	initial begin
		seed_ret = $urandom(32'h9bba);
		$timeformat(-9, 1, " ns", 0);
		arst_n_i = 1'b0;
		sample_i = '0;
		sample_valid_i = 1'b0;
		delta_ready_i = 1'b0;
		ready_mode = READY_ALWAYS;
		accepted_cnt = 0;
		stall_taken = 0;
		repeat (4) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		@(negedge clk);
		check_value("delta_valid_o after reset", longint'(delta_valid_o), 0);
		check_value("sample_ready_o after reset", longint'(sample_ready_o), 1);
		@(posedge clk);
		#2;

		// One frame without stalls and with bounded latency
		repeat (out_layer_pkg::FRAME_LEN) send_sample(random_sample(out_layer_pkg::COST_XENT));
		wait_first_output(10);
		wait_drained(50);

		// Cross-entropy under random back-pressure
		ready_mode = READY_RANDOM;
		repeat (8 * out_layer_pkg::FRAME_LEN)
			send_sample(random_sample(out_layer_pkg::COST_XENT));

		// Two frames of saturation corners and floor rounding
		send_sample(make_sample(16'sh7fff, 16'sh7fff, 1'b0, out_layer_pkg::COST_QUAD));
		send_sample(make_sample(16'sh8000, 16'sh7fff, 1'b1, out_layer_pkg::COST_QUAD));
		send_sample(make_sample(16'sh8000, 16'sh0000, 1'b1, out_layer_pkg::COST_XENT));
		send_sample(make_sample(16'sh0c00, 16'sh0200, 1'b1, out_layer_pkg::COST_QUAD));
		send_sample(make_sample(16'shffff, 16'sh0200, 1'b0, out_layer_pkg::COST_QUAD));
		send_sample(make_sample(16'sh7fff, 16'sh0000, 1'b1, out_layer_pkg::COST_XENT));
		send_sample(make_sample(16'sh7000, 16'sh8000, 1'b0, out_layer_pkg::COST_QUAD));
		send_sample(make_sample(16'sh0000, 16'sh7fff, 1'b1, out_layer_pkg::COST_QUAD));

		// Random quadratic then mixed opcodes
		repeat (8 * out_layer_pkg::FRAME_LEN)
			send_sample(random_sample(out_layer_pkg::COST_QUAD));
		repeat (4 * out_layer_pkg::FRAME_LEN)
			send_sample(random_sample(out_layer_pkg::cost_e'($urandom_range(0, 1))));
		wait_drained(500);

		// Long stall fills both banks plus the producer register
		ready_mode = READY_STALL;
		fill_under_stall(40, stall_taken);
		check_value("sample_ready_o during long stall", longint'(sample_ready_o), 0);
		check_value("samples taken under stall within two frames plus one",
			longint'(stall_taken <= 2 * out_layer_pkg::FRAME_LEN + 1), 1);

		// Release and complete the open frame
		ready_mode = READY_RANDOM;
		while (accepted_cnt % out_layer_pkg::FRAME_LEN != 0)
			send_sample(random_sample(out_layer_pkg::COST_XENT));
		wait_drained(500);
		check_value("delta_valid_o once all deltas arrived", longint'(delta_valid_o), 0);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/out_layer_pkg.sv
hdl/delta_calc.sv
hdl/delta_pingpong_mem.sv
hdl/delta_stream_out.sv
hdl/output_layer_top.sv
test/tb_output_layer.sv

/* Makefile */
# Verilator build and run of the output layer testbench
# Any variable below can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_output_layer
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
